// File: logic/merge_pkg.sv
`default_nettype none

package merge_pkg;

   localparam int DATA_W     = 32;
   localparam int DELAY_W    = 7;
   localparam int LANES      = 32;
   localparam int LANE_IDX_W = 5;
   localparam int ADDR_W     = 6;

   typedef logic [DATA_W-1:0]     data_t;      // Lane or stream word
   typedef logic [DELAY_W-1:0]    delay_t;     // Start delay in cycles
   typedef logic [LANE_IDX_W-1:0] lane_idx_t;  // Lane number
   typedef logic [ADDR_W-1:0]     addr_t;      // Host register address

   // Addresses 0..31 select the lane words
   localparam addr_t ADDR_DELAY = addr_t'(32);
   localparam addr_t ADDR_START = addr_t'(33);  // Data ignored

endpackage

`default_nettype wire

// File: logic/unit_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface unit_ctrl_if;

   logic                 run;      // One-cycle start pulse
   logic                 running;  // High from run until done
   merge_pkg::delay_t    delay;    // Held start delay
   logic                 done;     // One-cycle end pulse

   modport ctrl (
      output run,
      output running,
      output delay,
      input  done
   );

   modport unit (
      input run,
      input delay
   );

   modport sink (
      input  run,
      output done
   );

endinterface

`default_nettype wire

// File: logic/config_regs.sv
`timescale 1ns/10ps
`default_nettype none

module config_regs (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr_en,
   input  merge_pkg::addr_t  wr_addr,
   input  merge_pkg::data_t  wr_data,
   output logic              busy,
   unit_ctrl_if.ctrl         ctrl
);

   logic locked;
   logic delay_wr;
   logic start_wr;

   // A run in flight or just issued blocks further control writes
   assign locked   = ctrl.run | ctrl.running;
   assign delay_wr = wr_en && (wr_addr == merge_pkg::ADDR_DELAY) && !locked;
   assign start_wr = wr_en && (wr_addr == merge_pkg::ADDR_START) && !locked;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl.delay <= '0;
      end else if (delay_wr) begin
         ctrl.delay <= wr_data[merge_pkg::DELAY_W-1:0];  // Upper bits dropped
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl.run <= 1'b0;
      end else begin
         ctrl.run <= start_wr;  // Registered, one cycle wide
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl.running <= 1'b0;
      end else if (ctrl.run) begin
         ctrl.running <= 1'b1;
      end else if (ctrl.done) begin
         ctrl.running <= 1'b0;  // Sink has collected all words
      end
   end

   assign busy = ctrl.running;

endmodule

`default_nettype wire

// File: logic/lane_bank.sv
`timescale 1ns/10ps
`default_nettype none

module lane_bank (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr_en,
   input  merge_pkg::addr_t  wr_addr,
   input  merge_pkg::data_t  wr_data,
   unit_ctrl_if.unit         ctrl,
   output merge_pkg::data_t  lanes [0:merge_pkg::LANES-1]
);

   merge_pkg::data_t     host [0:merge_pkg::LANES-1];  // Host-written copies
   merge_pkg::data_t     snap [1:merge_pkg::LANES-1];  // Lane 0 loads directly
   merge_pkg::lane_idx_t rel_cnt;
   logic                 rel_active;
   logic                 lane_wr;

   assign lane_wr = wr_en && (wr_addr < merge_pkg::addr_t'(merge_pkg::LANES));

   // Host copy always writable, the snapshot shields the current run
   always_ff @(posedge clk) begin
      if (lane_wr) begin
         host[wr_addr[merge_pkg::LANE_IDX_W-1:0]] <= wr_data;
      end
   end

   // Release counter, lane k is let through k cycles after run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rel_cnt    <= '0;
         rel_active <= 1'b0;
      end else if (ctrl.run) begin
         rel_cnt    <= merge_pkg::lane_idx_t'(1);
         rel_active <= 1'b1;
      end else if (rel_active) begin
         rel_cnt <= rel_cnt + 1'b1;
         if (rel_cnt == merge_pkg::lane_idx_t'(merge_pkg::LANES - 1)) begin
            rel_active <= 1'b0;  // Last lane released
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.run) begin
         lanes[0] <= host[0];  // Zero latency lane
         for (int k = 1; k < merge_pkg::LANES; k++) begin
            snap[k] <= host[k];
         end
      end
      for (int k = 1; k < merge_pkg::LANES; k++) begin
         if (rel_active && rel_cnt == merge_pkg::lane_idx_t'(k)) begin
            lanes[k] <= snap[k];
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/merge_unit.sv
`timescale 1ns/10ps
`default_nettype none

module merge_unit (
   input  logic              clk,
   input  logic              rst,
   unit_ctrl_if.unit         ctrl,
   input  merge_pkg::data_t  lanes [0:merge_pkg::LANES-1],
   output merge_pkg::data_t  stream_data,
   output logic              stream_valid
);

   merge_pkg::delay_t    dly_cnt;
   merge_pkg::lane_idx_t lane_cnt;
   logic                 emit_active;  // First pass over the lanes pending
   logic                 dly_zero;

   assign dly_zero = (dly_cnt == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dly_cnt      <= '0;
         lane_cnt     <= '0;
         emit_active  <= 1'b0;
         stream_valid <= 1'b0;
      end else if (ctrl.run) begin
         dly_cnt      <= ctrl.delay;
         lane_cnt     <= '0;
         emit_active  <= 1'b1;
         stream_valid <= 1'b0;
      end else begin
         if (!dly_zero) begin
            dly_cnt <= dly_cnt - 1'b1;
         end else begin
            lane_cnt <= lane_cnt + 1'b1;  // Wraps freely after the pass
            if (lane_cnt == merge_pkg::lane_idx_t'(merge_pkg::LANES - 1)) begin
               emit_active <= 1'b0;
            end
         end
         stream_valid <= emit_active && dly_zero;
      end
   end

   // Output mux register, qualified by stream_valid
   always_ff @(posedge clk) begin
      stream_data <= lanes[lane_cnt];
   end

endmodule

`default_nettype wire

// File: logic/stream_sink.sv
`timescale 1ns/10ps
`default_nettype none

module stream_sink (
   input  logic              clk,
   input  logic              rst,
   input  merge_pkg::data_t  stream_data,
   input  logic              stream_valid,
   unit_ctrl_if.sink         ctrl,
   output merge_pkg::data_t  sum,
   output merge_pkg::data_t  checksum
);

   merge_pkg::lane_idx_t word_cnt;
   logic                 last_word;

   assign last_word = stream_valid &&
                      (word_cnt == merge_pkg::lane_idx_t'(merge_pkg::LANES - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sum      <= '0;
         checksum <= '0;
         word_cnt <= '0;
      end else if (ctrl.run) begin
         sum      <= '0;
         checksum <= '0;
         word_cnt <= '0;
      end else if (stream_valid) begin
         sum      <= sum + stream_data;  // Wrapping add
         checksum <= checksum ^ stream_data;
         word_cnt <= word_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl.done <= 1'b0;
      end else begin
         ctrl.done <= last_word;  // Same edge as final sum
      end
   end

endmodule

`default_nettype wire

// File: logic/merge_top.sv
`timescale 1ns/10ps
`default_nettype none

module merge_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr_en,
   input  merge_pkg::addr_t  wr_addr,
   input  merge_pkg::data_t  wr_data,
   output logic              busy,
   output logic              done,
   output merge_pkg::data_t  out_data,
   output logic              out_valid,
   output merge_pkg::data_t  sum,
   output merge_pkg::data_t  checksum
);

   merge_pkg::data_t lanes [0:merge_pkg::LANES-1];  // Skewed lane words

   unit_ctrl_if ctrl_if ();

   config_regs u_config_regs (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .busy    (busy),
      .ctrl    (ctrl_if.ctrl)
   );

   lane_bank u_lane_bank (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .ctrl    (ctrl_if.unit),
      .lanes   (lanes)
   );

   merge_unit u_merge_unit (
      .clk          (clk),
      .rst          (rst),
      .ctrl         (ctrl_if.unit),
      .lanes        (lanes),
      .stream_data  (out_data),
      .stream_valid (out_valid)
   );

   stream_sink u_stream_sink (
      .clk          (clk),
      .rst          (rst),
      .stream_data  (out_data),
      .stream_valid (out_valid),
      .ctrl         (ctrl_if.sink),
      .sum          (sum),
      .checksum     (checksum)
   );

   assign done = ctrl_if.done;

endmodule

`default_nettype wire

// File: test/merge_checker.sv
`timescale 1ns/10ps
`default_nettype none

module merge_checker (
   input logic clk,
   input logic rst,
   input logic run,
   input logic busy,
   input logic done,
   input logic out_valid
);

   run_single: assert property (@(posedge clk) disable iff (rst)
      !(run && $past(run)))
      else $error("run high for more than one cycle");

   done_in_run: assert property (@(posedge clk) disable iff (rst)
      done |-> busy)
      else $error("done pulse while not running");

   // Stream only flows inside a run
   valid_in_run: assert property (@(posedge clk) disable iff (rst)
      !busy |-> !out_valid)
      else $error("out_valid high while not busy");

endmodule

bind merge_top merge_checker u_merge_checker (
   .clk       (clk),
   .rst       (rst),
   .run       (ctrl_if.run),
   .busy      (busy),
   .done      (done),
   .out_valid (out_valid)
);

`default_nettype wire

// File: test/merge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module merge_tb;

   localparam int NUM_TESTS   = 7;               // Reset check plus six records
   localparam int TEST_CYCLES = 128 + 34 + 40;   // Longest delay, run, margin
   localparam int LANES       = merge_pkg::LANES;

   logic             clk;
   logic             rst;
   logic             wr_en;
   merge_pkg::addr_t wr_addr;
   merge_pkg::data_t wr_data;
   logic             busy;
   logic             done;
   merge_pkg::data_t out_data;
   logic             out_valid;
   merge_pkg::data_t sum;
   merge_pkg::data_t checksum;

   merge_pkg::data_t lane_val [0:LANES-1];  // Model of the host lane copies
   integer           seed;
   int               errors;
   int               test_errors;
   int               tests_run;
   int               tests_failed;

   merge_top DUT (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .busy      (busy),
      .done      (done),
      .out_data  (out_data),
      .out_valid (out_valid),
      .sum       (sum),
      .checksum  (checksum)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, a run hung", NUM_TESTS * TEST_CYCLES);
      $display("Test failed");
      $finish;
   end

   task automatic report_err(input string name, input merge_pkg::data_t exp,
                             input merge_pkg::data_t act);
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      test_errors++;
   endtask

   task automatic report_fail(input string what);
      $display("At %0t %s", $time, what);
      test_errors++;
   endtask

   // Called on a falling edge, returns on the next one
   task automatic write_reg(input merge_pkg::addr_t addr, input merge_pkg::data_t data);
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      @(negedge clk);
      wr_en   = 1'b0;
   endtask

   task automatic load_lanes();
      for (int k = 0; k < LANES; k++) begin
         write_reg(merge_pkg::addr_t'(k), lane_val[k]);
      end
   endtask

   task automatic finish_test(input int id, input int dly);
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
         $display("test %0d delay %0d: FAIL, %0d errors", id, dly, test_errors);
      end else begin
         $display("test %0d delay %0d: pass", id, dly);
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   // One run from start write to done. With disturb set, two more start
   // writes and a write of new_lane to lane 7 arrive during the run.
   task automatic run_stream(input int dly, input bit disturb,
                             input merge_pkg::data_t new_lane);
      merge_pkg::data_t exp_sum;
      merge_pkg::data_t exp_chk;
      int               n;
      int               vcount;
      int               done_n;
      exp_sum = '0;
      exp_chk = '0;
      for (int k = 0; k < LANES; k++) begin
         exp_sum = exp_sum + lane_val[k];  // Wraps at 32 bits
         exp_chk = exp_chk ^ lane_val[k];
      end
      write_reg(merge_pkg::ADDR_DELAY, merge_pkg::data_t'(dly));
      write_reg(merge_pkg::ADDR_START, '0);
      n      = 0;  // Falling edges since the start write was sampled
      vcount = 0;
      done_n = -1;
      while (done_n < 0 && n < dly + 34 + 40) begin
         wr_en = 1'b0;
         if (disturb && (n == 0 || n == 2)) begin
            wr_en   = 1'b1;
            wr_addr = merge_pkg::ADDR_START;
            wr_data = '0;
         end
         if (disturb && n == 3) begin
            wr_en   = 1'b1;
            wr_addr = merge_pkg::addr_t'(7);
            wr_data = new_lane;
         end
         @(negedge clk);
         n++;
         if (busy !== 1'b1) begin
            report_err("busy", merge_pkg::data_t'(1), merge_pkg::data_t'(busy));
         end
         if (out_valid) begin
            if (vcount >= LANES) begin
               report_fail("out_valid high for more than 32 cycles");
            end else begin
               if (n != dly + 2 + vcount) begin
                  report_err("out_valid cycle", dly + 2 + vcount, n);
               end
               if (out_data !== lane_val[vcount]) begin
                  report_err("out_data", lane_val[vcount], out_data);
               end
            end
            vcount++;
         end
         if (done) begin
            done_n = n;
         end
      end
      wr_en = 1'b0;
      if (done_n < 0) begin
         report_fail("done never arrived");
      end else begin
         if (done_n != dly + 34) begin
            report_err("done cycle", dly + 34, done_n);
         end
         if (vcount != LANES) begin
            report_err("out_valid count", LANES, vcount);
         end
         if (sum !== exp_sum) begin
            report_err("sum", exp_sum, sum);
         end
         if (checksum !== exp_chk) begin
            report_err("checksum", exp_chk, checksum);
         end
      end
      repeat (4) begin
         @(negedge clk);
         if (busy !== 1'b0) begin
            report_err("busy", '0, merge_pkg::data_t'(busy));
         end
         if (out_valid !== 1'b0 || done !== 1'b0) begin
            report_fail("out_valid or done high after the run ended");
         end
         if (sum !== exp_sum) begin
            report_err("sum after done", exp_sum, sum);
         end
      end
   endtask

   initial begin
      int               fd;
      int               nread;
      int               id;
      int               dly;
      int               mode;
      string            line;
      merge_pkg::data_t word;
      seed         = 23517;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      wr_en        = 1'b0;
      wr_addr      = '0;
      wr_data      = '0;
      rst          = 1'b1;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      if (busy !== 1'b0) begin
         report_err("busy", '0, merge_pkg::data_t'(busy));
      end
      if (done !== 1'b0) begin
         report_err("done", '0, merge_pkg::data_t'(done));
      end
      if (out_valid !== 1'b0) begin
         report_err("out_valid", '0, merge_pkg::data_t'(out_valid));
      end
      if (sum !== '0) begin
         report_err("sum", '0, sum);
      end
      if (checksum !== '0) begin
         report_err("checksum", '0, checksum);
      end
      finish_test(0, 0);

      fd = $fopen("test/merge_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test/merge_testdata.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            nread = $fgets(line, fd);
            // Comment and blank lines do not parse as a header
            if (nread > 0 && $sscanf(line, "%d %d %d", id, dly, mode) == 3) begin
               for (int k = 0; k < LANES; k++) begin
                  nread = $fscanf(fd, "%h", word);
                  if (nread != 1) begin
                     report_fail("short lane record in test data");
                  end
                  lane_val[k] = (mode == 1) ? $random(seed) : word;
               end
               load_lanes();
               run_stream(dly, mode == 2, ~lane_val[7]);
               if (mode == 2) begin
                  lane_val[7] = ~lane_val[7];  // Busy-time write shows in the next run
                  run_stream(dly, 1'b0, '0);
               end
               finish_test(id, dly);
            end
         end
         $fclose(fd);
      end
      if (tests_run != NUM_TESTS) begin
         $display("Only %0d of %0d tests ran", tests_run, NUM_TESTS);
         errors++;
      end

      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/merge_testdata.txt
# Header line: test id, start delay, mode (0 lanes below, 1 random lanes, 2 writes while busy)
# Then 32 lane words in hex, eight per line, ignored in mode 1
1 0 0
a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
a0000008 a0000009 a000000a a000000b a000000c a000000d a000000e a000000f
a0000010 a0000011 a0000012 a0000013 a0000014 a0000015 a0000016 a0000017
a0000018 a0000019 a000001a a000001b a000001c a000001d a000001e a000001f
2 5 0
12345678 9abcdef0 0f1e2d3c 4b5a6978 87a5c3e1 deadbeef cafef00d 01234567
89abcdef fedcba98 76543210 13579bdf 2468ace0 55aa55aa aa55aa55 0badc0de
feedface 8badf00d 1badb002 c001d00d 00ff00ff ff00ff00 0f0f0f0f f0f0f0f0
31415926 27182818 16180339 14142135 17320508 22360679 69314718 57721566
3 100 0
00000001 00000002 00000004 00000008 00000010 00000020 00000040 00000080
00000100 00000200 00000400 00000800 00001000 00002000 00004000 00008000
00010000 00020000 00040000 00080000 00100000 00200000 00400000 00800000
01000000 02000000 04000000 08000000 10000000 20000000 40000000 80000000
4 17 1
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
5 3 0
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
6 9 2
c0de0000 c0de0001 c0de0002 c0de0003 c0de0004 c0de0005 c0de0006 c0de0007
c0de0008 c0de0009 c0de000a c0de000b c0de000c c0de000d c0de000e c0de000f
c0de0010 c0de0011 c0de0012 c0de0013 c0de0014 c0de0015 c0de0016 c0de0017
c0de0018 c0de0019 c0de001a c0de001b c0de001c c0de001d c0de001e c0de001f

// File: compile.f
logic/merge_pkg.sv
logic/unit_ctrl_if.sv
logic/config_regs.sv
logic/lane_bank.sv
logic/merge_unit.sv
logic/stream_sink.sv
logic/merge_top.sv
test/merge_checker.sv
test/merge_tb.sv

// File: run.sh
#!/bin/sh
# Build the merge testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module merge_tb \
   -f compile.f -Mdir obj_dir -o merge_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/merge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
   echo "No result line found in $LOG"
   exit 1
fi

exit 0
